// ==== Bender.yml ====
package:
  name: dir_cam

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dir_pkg.sv
      - dir_tag_array.sv
      - dir_cam_match.sv
      - dir_panel.sv
      - dir_cam.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - dir_cam_sva.sv
      - tb_dir_cam.sv

// ==== dir_cam.sv ====
// L2 directory CAM top; four independent panels whose lookup hits are ORed into row_hit
`timescale 1ns/1ps
`default_nettype none

`include "dir_params.svh"

module dir_cam
   import dir_pkg::*;
(
   input  wire logic                          rclk,
   input  wire logic                          rst_l,
   input  wire dir_req_t [`DIR_PANELS-1:0]    req,       // One request per panel
   output dir_rd_t  [`DIR_PANELS-1:0]         rd_data,
   output logic     [`DIR_ROWS-1:0]           row_hit
);

   logic [`DIR_PANELS-1:0][`DIR_ROWS-1:0] pair_hit;

   //////////////////////////////
   // Panels
   //////////////////////////////

   for (genvar p = 0; p < `DIR_PANELS; p++) begin : g_panel
      dir_panel i_panel (
         .rclk     (rclk),
         .rst_l    (rst_l),
         .req      (req[p]),
         .rd_data  (rd_data[p]),
         .pair_hit (pair_hit[p])
      );
   end

   //////////////////////////////
   // Row hit
   //////////////////////////////

   // Any panel hitting a pair flags that row
   always_comb begin
      row_hit = '0;
      for (int p = 0; p < `DIR_PANELS; p++) begin
         row_hit = row_hit | pair_hit[p];
      end
   end

endmodule

`default_nettype wire

// ==== dir_cam_match.sv ====
// Lookup compare of one directory panel; folds entry matches into pair hits and clears
`timescale 1ns/1ps
`default_nettype none

`include "dir_params.svh"

module dir_cam_match
   import dir_pkg::*;
(
   input  wire dir_req_t                                req_d,
   input  wire logic [`DIR_ENTRIES-1:0][`DIR_TAG_W-1:0] tags,
   input  wire logic [`DIR_ENTRIES-1:0]                 valid,
   output logic [`DIR_ROWS-1:0]                         pair_hit,
   output logic [`DIR_ENTRIES-1:0]                      clr_valid
);

   localparam int GRP_SZ = `DIR_ENTRIES / `DIR_MASK_W;   // Entries per mask bit

   dir_lkup_key_t           key;
   logic [`DIR_ENTRIES-1:0] ent_hit;

   assign key = req_d.word.lkup;

   //////////////////////////////
   // Per-entry compare
   //////////////////////////////

   // Only the even or the odd half of each pair takes part
   for (genvar e = 0; e < `DIR_ENTRIES; e++) begin : g_ent
      localparam bit ODD = (e % 2) == 1;

      assign ent_hit[e] = req_d.cam_en
                        & valid[e]
                        & (tags[e] == key.tag)
                        & (key.odd_sel == ODD);

      // Invalidate only inside selected groups of eight
      assign clr_valid[e] = ent_hit[e] & req_d.inv_mask[e / GRP_SZ];
   end

   //////////////////////////////
   // Pair fold
   //////////////////////////////

   for (genvar k = 0; k < `DIR_ROWS; k++) begin : g_row
      assign pair_hit[k] = ent_hit[2*k] | ent_hit[2*k+1];
   end

endmodule

`default_nettype wire

// ==== dir_cam_sva.sv ====
// Protocol and timing assertions for the directory CAM; bound into the top level for simulation
`timescale 1ns/1ps
`default_nettype none

`include "dir_params.svh"

module dir_cam_sva
   import dir_pkg::*;
(
   input  wire logic                     rclk,
   input  wire logic                     rst_l,
   input  wire dir_req_t [`DIR_PANELS-1:0] req,
   input  wire dir_rd_t  [`DIR_PANELS-1:0] rd_data,
   input  wire logic [`DIR_ROWS-1:0]     row_hit
);

   int   fails = 0;   // Read by the testbench at the end
   logic any_cam;

   always_comb begin
      any_cam = 1'b0;
      for (int p = 0; p < `DIR_PANELS; p++) begin
         any_cam = any_cam | req[p].cam_en;
      end
   end

   ////////////////////////////////
   // Row hit
   ////////////////////////////////

   a_idle_no_hit: assert property (@(posedge rclk) !any_cam |=> row_hit == '0)
      else begin
         fails++;
         $error("row_hit set one cycle after a cycle with no lookup");
      end

   a_reset_no_hit: assert property (@(posedge rclk) !rst_l |=> row_hit == '0)
      else begin
         fails++;
         $error("row_hit set after a reset edge");
      end

   ////////////////////////////////
   // Per panel
   ////////////////////////////////

   for (genvar p = 0; p < `DIR_PANELS; p++) begin : g_panel
      a_no_cam_wr: assert property (@(posedge rclk) !(req[p].cam_en && req[p].wr_en))
         else begin
            fails++;
            $error("Panel %0d got lookup and write together", p);
         end

      // rd_data moves only two edges after a read or write request
      a_rd_hold: assert property (@(posedge rclk) disable iff (!rst_l)
            (!req[p].rd_en && !req[p].wr_en) |=> ##1 $stable(rd_data[p]))
         else begin
            fails++;
            $error("Panel %0d rd_data changed without a read or write", p);
         end
   end

endmodule

bind dir_cam dir_cam_sva i_sva (.*);

`default_nettype wire

// ==== dir_panel.sv ====
// One directory panel; registers its request and runs storage and lookup from it
`timescale 1ns/1ps
`default_nettype none

`include "dir_params.svh"

module dir_panel
   import dir_pkg::*;
(
   input  wire logic             rclk,
   input  wire logic             rst_l,
   input  wire dir_req_t         req,
   output dir_rd_t               rd_data,
   output logic [`DIR_ROWS-1:0]  pair_hit
);

   dir_req_t                                req_d;
   logic [`DIR_ENTRIES-1:0][`DIR_TAG_W-1:0] tags;
   logic [`DIR_ENTRIES-1:0]                 valid;
   logic [`DIR_ENTRIES-1:0]                 clr_valid;

   //////////////////////////////
   // Request register
   //////////////////////////////

   // Payload follows the input, strobes cleared by reset
   always_ff @(posedge rclk) begin
      req_d <= req;
      if (!rst_l) begin
         req_d.rd_en  <= 1'b0;
         req_d.wr_en  <= 1'b0;
         req_d.cam_en <= 1'b0;
      end
   end

   //////////////////////////////
   // Storage and lookup
   //////////////////////////////

   dir_tag_array i_tag_array (
      .rclk      (rclk),
      .rst_l     (rst_l),
      .req_d     (req_d),
      .clr_valid (clr_valid),
      .tags      (tags),
      .valid     (valid),
      .rd_data   (rd_data)
   );

   // Hit lines stay combinational off req_d
   dir_cam_match i_cam_match (
      .req_d     (req_d),
      .tags      (tags),
      .valid     (valid),
      .pair_hit  (pair_hit),
      .clr_valid (clr_valid)
   );

endmodule

`default_nettype wire

// ==== dir_params.svh ====
// Size constants for the L2 directory CAM; include wherever panel geometry is needed
`ifndef DIR_PARAMS_SVH
`define DIR_PARAMS_SVH

//////////////////////////////
// Array geometry
//////////////////////////////

// Panels per directory, one per addr<10:9> decode
`define DIR_PANELS 4

`define DIR_ENTRIES 64   // Entries per panel
`define DIR_ADDR_W 6     // Entry address width

// Tag holds addr<39:10>
`define DIR_TAG_W 30

// Entry pairs per panel, also the row hit width
`define DIR_ROWS 32

//////////////////////////////
// Request word
//////////////////////////////

// One mask bit per group of eight entries
`define DIR_MASK_W 8

// Write entry or lookup key, same width
`define DIR_WORD_W 33

`endif

// ==== dir_pkg.sv ====
// Request and read types for the directory CAM; import into any module that uses them
`default_nettype none

`include "dir_params.svh"

package dir_pkg;

   //////////////////////////////
   // Request word views
   //////////////////////////////

   // Write view {tag, unused, parity, valid}
   typedef struct packed {
      logic [`DIR_TAG_W-1:0]               tag;
      logic [`DIR_WORD_W-`DIR_TAG_W-3:0]   rsvd;    // addr<8> on a write, ignored
      logic                                parity;
      logic                                valid;
   } dir_wr_entry_t;

   // Lookup view {tag, odd_sel, unused}
   typedef struct packed {
      logic [`DIR_TAG_W-1:0]               tag;
      logic                                odd_sel; // Set to compare odd entries
      logic [`DIR_WORD_W-`DIR_TAG_W-2:0]   rsvd;
   } dir_lkup_key_t;

   // Same bits, decoded by what the request does
   typedef union packed {
      dir_wr_entry_t wr;
      dir_lkup_key_t lkup;
   } dir_word_u;

   //////////////////////////////
   // Panel request and read data
   //////////////////////////////

   typedef struct packed {
      logic                     rd_en;
      logic                     wr_en;
      logic                     cam_en;
      logic [`DIR_ADDR_W-1:0]   rw_addr;
      logic [`DIR_MASK_W-1:0]   inv_mask;  // Groups allowed to invalidate on hit
      dir_word_u                word;
   } dir_req_t;

   // Read port layout {tag, parity, valid}
   typedef struct packed {
      logic [`DIR_TAG_W-1:0] tag;
      logic                  parity;
      logic                  valid;
   } dir_rd_t;

endpackage

`default_nettype wire

// ==== dir_tag_array.sv ====
// Tag, parity and valid storage of one directory panel, driven by the registered request
`timescale 1ns/1ps
`default_nettype none

`include "dir_params.svh"

module dir_tag_array
   import dir_pkg::*;
(
   input  wire logic                                    rclk,
   input  wire logic                                    rst_l,
   input  wire dir_req_t                                req_d,
   input  wire logic [`DIR_ENTRIES-1:0]                 clr_valid,
   output logic [`DIR_ENTRIES-1:0][`DIR_TAG_W-1:0]      tags,
   output logic [`DIR_ENTRIES-1:0]                      valid,
   output dir_rd_t                                      rd_data
);

   logic [`DIR_ENTRIES-1:0] parity;
   logic [`DIR_ENTRIES-1:0] valid_nxt;
   dir_wr_entry_t           wr_ent;

   assign wr_ent = req_d.word.wr;   // Write view of the request word

   //////////////////////////////
   // Tag and parity store
   //////////////////////////////

   always_ff @(posedge rclk) begin
      if (req_d.wr_en) begin
         tags[req_d.rw_addr]   <= wr_ent.tag;
         parity[req_d.rw_addr] <= wr_ent.parity;
      end
   end

   //////////////////////////////
   // Valid bits
   //////////////////////////////

   // Lookup clears first, then a write loads its own valid bit
   always_comb begin
      valid_nxt = valid & ~clr_valid;
      if (req_d.wr_en) begin
         valid_nxt[req_d.rw_addr] = wr_ent.valid;
      end
   end

   always_ff @(posedge rclk) begin
      if (!rst_l) begin
         valid <= '0;
      end else begin
         valid <= valid_nxt;
      end
   end

   //////////////////////////////
   // Read port
   //////////////////////////////

   // Write wins over a read in the same cycle
   always_ff @(posedge rclk) begin
      if (!rst_l) begin
         rd_data <= '0;
      end else if (req_d.wr_en) begin
         rd_data.tag    <= wr_ent.tag;        // Write-through
         rd_data.parity <= wr_ent.parity;
         rd_data.valid  <= wr_ent.valid;
      end else if (req_d.rd_en) begin
         rd_data.tag    <= tags[req_d.rw_addr];
         rd_data.parity <= parity[req_d.rw_addr];
         rd_data.valid  <= valid[req_d.rw_addr];   // Value before this edge's clear
      end
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
dir_pkg.sv
dir_tag_array.sv
dir_cam_match.sv
dir_panel.sv
dir_cam.sv
dir_cam_sva.sv
tb_dir_cam.sv

// ==== tb_dir_cam.sv ====
// Testbench for the directory CAM; runs directed and random traffic against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "dir_params.svh"

module tb_dir_cam
   import dir_pkg::*;
();

   localparam logic [`DIR_TAG_W-1:0] TAG_A    = 30'h0123_4567;
   localparam logic [`DIR_TAG_W-1:0] TAG_B    = 30'h2bad_cafe;
   localparam logic [`DIR_TAG_W-1:0] TAG_C    = 30'h1555_aaaa;
   localparam logic [`DIR_TAG_W-1:0] TAG_D    = 30'h0f0f_1234;
   localparam logic [`DIR_TAG_W-1:0] TAG_POOL = 30'h1b2c_3d00;   // Random tags, low 2 bits vary

   logic                        rclk;
   logic                        rst_l;
   dir_req_t [`DIR_PANELS-1:0]  req;
   dir_rd_t  [`DIR_PANELS-1:0]  rd_data;
   logic     [`DIR_ROWS-1:0]    row_hit;

   ////////////////////////////////
   // Reference model
   ////////////////////////////////

   logic [`DIR_TAG_W-1:0]       m_tag [`DIR_PANELS][`DIR_ENTRIES];
   logic                        m_par [`DIR_PANELS][`DIR_ENTRIES];
   logic                        m_val [`DIR_PANELS][`DIR_ENTRIES];
   dir_req_t [`DIR_PANELS-1:0]  pend;     // Driven, not yet sampled
   dir_req_t [`DIR_PANELS-1:0]  regd;     // What the panels hold in req_d
   dir_rd_t  [`DIR_PANELS-1:0]  exp_rd;
   logic     [`DIR_ROWS-1:0]    exp_hit;
   int                          errors;
   int                          tests;
   int                          seed;

   initial rclk = 1'b0;
   always #50 rclk = ~rclk;

   dir_cam i_dut (.rclk(rclk), .rst_l(rst_l), .req(req), .rd_data(rd_data), .row_hit(row_hit));

   function automatic dir_req_t mk_req(logic rd, logic wr, logic cam, logic [5:0] addr,
                                       logic [7:0] mask, logic [`DIR_WORD_W-1:0] word);
      dir_req_t r;
      r = '0;
      r.rd_en    = rd;
      r.wr_en    = wr;
      r.cam_en   = cam;
      r.rw_addr  = addr;
      r.inv_mask = mask;
      r.word     = word;
      return r;
   endfunction

   // Entry takes part only on its own half of the pair
   function automatic logic ent_match(int p, int e, dir_req_t r);
      return r.cam_en && m_val[p][e] && (m_tag[p][e] == r.word.lkup.tag)
             && (r.word.lkup.odd_sel == e[0]);
   endfunction

   task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
      errors++;
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
   endtask

   // Applies the request leaving req_d at this edge
   task automatic advance_model(input dir_req_t [`DIR_PANELS-1:0] nxt);
      dir_req_t r;
      int       a;
      for (int p = 0; p < `DIR_PANELS; p++) begin
         r = regd[p];
         a = r.rw_addr;
         if (r.wr_en) begin
            exp_rd[p] = {r.word.wr.tag, r.word.wr.parity, r.word.wr.valid};
         end else if (r.rd_en) begin
            exp_rd[p] = {m_tag[p][a], m_par[p][a], m_val[p][a]};
         end
         for (int e = 0; e < `DIR_ENTRIES; e++) begin
            if (ent_match(p, e, r) && r.inv_mask[e / (`DIR_ENTRIES / `DIR_MASK_W)]) begin
               m_val[p][e] = 1'b0;
            end
         end
         if (r.wr_en) begin
            m_tag[p][a] = r.word.wr.tag;
            m_par[p][a] = r.word.wr.parity;
            m_val[p][a] = r.word.wr.valid;
         end
      end
      regd = pend;
      pend = nxt;
   endtask

   // Drive on the rising edge, check mid-cycle
   task automatic cycle(input dir_req_t [`DIR_PANELS-1:0] nxt);
      @(posedge rclk);
      req <= nxt;
      advance_model(nxt);
      @(negedge rclk);
      exp_hit = '0;
      for (int p = 0; p < `DIR_PANELS; p++) begin
         for (int e = 0; e < `DIR_ENTRIES; e++) begin
            exp_hit[e / 2] = exp_hit[e / 2] | ent_match(p, e, regd[p]);
         end
      end
      assert (row_hit === exp_hit) else report_mismatch("row_hit", row_hit, exp_hit);
      for (int p = 0; p < `DIR_PANELS; p++) begin
         assert (rd_data[p] === exp_rd[p])
            else report_mismatch($sformatf("rd_data[%0d]", p), rd_data[p], exp_rd[p]);
      end
   endtask

   task automatic finish_test(string name);
      cycle('0);
      cycle('0);
      tests++;
      $display("Test %s finished, %0d errors so far", name, errors);
   endtask

   // Cycle limit for the whole run
   initial begin
      for (int c = 0; c < 2000; c++) begin
         @(posedge rclk);
      end
      $display("Timeout: the run did not finish within 2000 clock cycles");
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      dir_req_t [`DIR_PANELS-1:0] q;
      logic [31:0]                op;
      seed   = 32'hdcb8;
      errors = 0;
      tests  = 0;
      rst_l  = 1'b0;
      req    = '0;
      regd   = '0;
      pend   = '0;
      exp_rd = '0;
      for (int p = 0; p < `DIR_PANELS; p++) begin
         for (int e = 0; e < `DIR_ENTRIES; e++) begin
            m_val[p][e] = 1'b0;
         end
      end
      for (int c = 0; c < 5; c++) begin
         @(posedge rclk);
      end
      rst_l <= 1'b1;

      for (int p = 0; p < `DIR_PANELS; p++) begin
         op   = $random(seed);
         q[p] = mk_req(0, 0, 1, 0, 8'hff, {op[29:0], p[0], 2'b00});
      end
      cycle(q);
      finish_test("reset");

      // Every entry gets a known tag, valid left clear
      for (int a = 0; a < `DIR_ENTRIES; a++) begin
         for (int p = 0; p < `DIR_PANELS; p++) begin
            q[p] = mk_req(0, 1, 0, a, 0, {24'h3c5aa5, 6'(a), 1'b0, ^a, 1'b0});
         end
         cycle(q);
      end
      finish_test("preload");

      q    = '0;
      q[0] = mk_req(0, 1, 0, 5, 0, {TAG_A, 3'b011});
      cycle(q);
      q[0] = mk_req(1, 0, 0, 5, 0, '0);   // Read right behind the write
      cycle(q);
      cycle(q);
      finish_test("write_read");

      q    = '0;
      q[1] = mk_req(0, 1, 0, 12, 0, {TAG_B, 3'b001});
      q[2] = mk_req(0, 1, 0, 20, 0, {TAG_C, 3'b010});   // Stored without valid
      cycle(q);
      q    = '0;
      q[2] = mk_req(0, 1, 0, 41, 0, {TAG_D, 3'b001});
      q[3] = mk_req(0, 1, 0, 8, 0, {TAG_D, 3'b011});
      cycle(q);
      q    = '0;
      q[1] = mk_req(0, 0, 1, 0, 0, {TAG_B, 3'b000});
      cycle(q);
      q[1] = mk_req(0, 0, 1, 0, 0, {TAG_B, 3'b100});    // Wrong half
      cycle(q);
      q[1] = mk_req(0, 0, 1, 0, 0, {TAG_D, 3'b000});
      cycle(q);
      q    = '0;
      q[2] = mk_req(0, 0, 1, 0, 0, {TAG_C, 3'b000});
      cycle(q);
      q[2] = mk_req(0, 0, 1, 0, 0, {TAG_D, 3'b100});
      q[3] = mk_req(0, 0, 1, 0, 0, {TAG_D, 3'b000});
      cycle(q);
      finish_test("lookup");

      q    = '0;
      q[1] = mk_req(0, 0, 1, 0, 8'hfd, {TAG_B, 3'b000});   // Group 1 kept
      cycle(q);
      q[1] = mk_req(0, 0, 1, 0, 8'h02, {TAG_B, 3'b000});
      cycle(q);
      cycle(q);
      q[1] = mk_req(1, 0, 0, 12, 0, '0);
      cycle(q);
      finish_test("invalidate");

      // Read alone or with an op; write and lookup never together
      for (int c = 0; c < 300; c++) begin
         for (int p = 0; p < `DIR_PANELS; p++) begin
            op   = $random(seed);
            q[p] = mk_req(op[0], op[1] & ~op[2], op[1] & op[2], op[13:8], op[23:16],
                          {TAG_POOL | 30'(op[25:24]), op[28:26]});
         end
         cycle(q);
      end
      finish_test("random");

      errors = errors + i_dut.i_sva.fails;
      $display("Done: %0d tests, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire
